// ==== design/riscv.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module riscv (
  input  logic                clk,
  input  logic                reset,
  output logic                mem_valid,
  output logic                mem_instr,
  input  logic                mem_ready,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [`RV_XLEN-1:0] mem_wdata,
  output logic [3:0]          mem_wstrb,
  input  logic [`RV_XLEN-1:0] mem_rdata,
  output logic                trap
);

  import rv_pkg::*;

  logic                fetch_go;
  mem_req_t            fetch_req;
  logic                data_go;
  mem_req_t            data_req;
  logic                done;
  logic [`RV_XLEN-1:0] rdata;
  logic                instr_valid;
  logic [`RV_XLEN-1:0] instr;
  logic [`RV_XLEN-1:0] pc;
  decoded_t            dec;
  logic                next_go;
  logic [`RV_XLEN-1:0] next_pc;

  rv_fetch u_fetch (
    .clk(clk), .reset(reset), .next_go(next_go), .next_pc(next_pc), .done(done),
    .rdata(rdata), .fetch_go(fetch_go), .fetch_req(fetch_req),
    .instr_valid(instr_valid), .instr(instr), .pc(pc)
  );

  rv_decode u_decode (.instr(instr), .dec(dec));

  rv_execute u_execute (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .pc(pc), .dec(dec),
    .done(done), .rdata(rdata), .data_go(data_go), .data_req(data_req),
    .next_go(next_go), .next_pc(next_pc), .trap(trap)
  );

  rv_mem_port u_mem_port (
    .clk(clk), .reset(reset), .fetch_go(fetch_go), .fetch_req(fetch_req),
    .data_go(data_go), .data_req(data_req), .mem_valid(mem_valid),
    .mem_instr(mem_instr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
    .done(done), .rdata(rdata)
  );

endmodule

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode (
  input  logic [`RV_XLEN-1:0] instr,
  output rv_pkg::decoded_t    dec
);

  import rv_pkg::*;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec.rd       = instr[11:7];
    dec.rs1      = instr[19:15];
    dec.rs2      = instr[24:20];
    dec.funct3   = funct3;
    dec.alt      = instr[30];
    dec.op_class = class_illegal;
    dec.imm      = '0;
    case (opcode)
      7'b0110111: begin
        dec.op_class = class_lui;
        dec.imm      = imm_u;
      end
      7'b0010111: begin
        dec.op_class = class_auipc;
        dec.imm      = imm_u;
      end
      7'b1101111: begin
        dec.op_class = class_jal;
        dec.imm      = imm_j;
      end
      7'b1100111: begin
        if (funct3 == 3'b000) dec.op_class = class_jalr;
        dec.imm = imm_i;
      end
      7'b1100011: begin
        // funct3 010 and 011 are unused
        if (funct3[2:1] != 2'b01) dec.op_class = class_branch;
        dec.imm = imm_b;
      end
      7'b0000011: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          dec.op_class = class_load;
        end
        dec.imm = imm_i;
      end
      7'b0100011: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010}) dec.op_class = class_store;
        dec.imm = imm_s;
      end
      7'b0010011: begin
        // shift immediates carry funct7
        if ((funct3 == 3'b001 && funct7 != 7'b0000000) ||
            (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000)) begin
          dec.op_class = class_illegal;
        end else begin
          dec.op_class = class_op_imm;
        end
        dec.imm = imm_i;
      end
      7'b0110011: begin
        if (funct7 == 7'b0000000 ||
            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec.op_class = class_op;
        end
      end
      7'b1110011: begin
        // ecall and ebreak only
        if (funct3 == 3'b000) dec.op_class = class_system;
      end
      default: dec.op_class = class_illegal;
    endcase
  end

endmodule

// ==== design/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// data and address width
`define RV_XLEN 32

// architectural registers including x0
`define RV_NUM_REGS 32

`endif

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_execute (
  input  logic                clk,
  input  logic                reset,
  input  logic                instr_valid,
  input  logic [`RV_XLEN-1:0] pc,
  input  rv_pkg::decoded_t    dec,
  input  logic                done,
  input  logic [`RV_XLEN-1:0] rdata,
  output logic                data_go,
  output rv_pkg::mem_req_t    data_req,
  output logic                next_go,
  output logic [`RV_XLEN-1:0] next_pc,
  output logic                trap
);

  import rv_pkg::*;

  typedef enum logic [1:0] {st_idle, st_mem_wait, st_trapped} state_e;

  state_e              state;
  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];
  logic [`RV_XLEN-1:0] rs1_val;
  logic [`RV_XLEN-1:0] rs2_val;
  logic [`RV_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic [`RV_XLEN-1:0] alu_result;
  logic                branch_taken;
  logic [`RV_XLEN-1:0] link;
  logic [`RV_XLEN-1:0] pc_target;
  logic [`RV_XLEN-1:0] jalr_sum;
  logic [`RV_XLEN-1:0] target;
  logic                bad_target;
  logic [`RV_XLEN-1:0] ls_addr;
  logic                ls_misaligned;
  logic                wr_en;
  logic [`RV_XLEN-1:0] wr_data;

  // x0 reads as zero
  assign rs1_val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
  assign rs2_val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];
  assign op_b    = (dec.op_class == class_op_imm) ? dec.imm : rs2_val;
  assign shamt   = op_b[4:0];

  always_comb begin
    case (dec.funct3)
      3'b000:  alu_result = (dec.op_class == class_op && dec.alt) ? rs1_val - op_b
                                                                   : rs1_val + op_b;
      3'b001:  alu_result = rs1_val << shamt;
      3'b010:  alu_result = {31'b0, $signed(rs1_val) < $signed(op_b)};
      3'b011:  alu_result = {31'b0, rs1_val < op_b};
      3'b100:  alu_result = rs1_val ^ op_b;
      3'b101:  alu_result = dec.alt ? $unsigned($signed(rs1_val) >>> shamt)
                                    : rs1_val >> shamt;
      3'b110:  alu_result = rs1_val | op_b;
      default: alu_result = rs1_val & op_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      3'b000:  branch_taken = rs1_val == rs2_val;
      3'b001:  branch_taken = rs1_val != rs2_val;
      3'b100:  branch_taken = $signed(rs1_val) < $signed(rs2_val);
      3'b101:  branch_taken = $signed(rs1_val) >= $signed(rs2_val);
      3'b110:  branch_taken = rs1_val < rs2_val;
      default: branch_taken = rs1_val >= rs2_val;
    endcase
  end

  assign link      = pc + 32'd4;
  assign pc_target = pc + dec.imm;
  assign jalr_sum  = rs1_val + dec.imm;

  always_comb begin
    target = link;
    case (dec.op_class)
      class_jal:    target = pc_target;
      class_jalr:   target = {jalr_sum[`RV_XLEN-1:1], 1'b0};
      class_branch: if (branch_taken) target = pc_target;
      default:      target = link;
    endcase
  end

  assign bad_target = |target[1:0];

  // alignment by access size
  assign ls_addr = rs1_val + dec.imm;
  always_comb begin
    case (dec.funct3[1:0])
      2'b00:   ls_misaligned = 1'b0;
      2'b01:   ls_misaligned = ls_addr[0];
      default: ls_misaligned = |ls_addr[1:0];
    endcase
  end

  always_comb begin
    wr_en   = 1'b0;
    wr_data = alu_result;
    if (state == st_idle && instr_valid) begin
      case (dec.op_class)
        class_lui: begin
          wr_en   = 1'b1;
          wr_data = dec.imm;
        end
        class_auipc: begin
          wr_en   = 1'b1;
          wr_data = pc_target;
        end
        class_jal, class_jalr: begin
          wr_en   = !bad_target;
          wr_data = link;
        end
        class_op, class_op_imm: wr_en = 1'b1;
        default: wr_en = 1'b0;
      endcase
    end else if (state == st_mem_wait && done && !data_req.write) begin
      // load reply arrives already extended
      wr_en   = 1'b1;
      wr_data = rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && dec.rd != 5'd0) begin
      regs[dec.rd] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state   <= st_idle;
      next_go <= 1'b0;
      data_go <= 1'b0;
    end else begin
      next_go <= 1'b0;
      data_go <= 1'b0;
      case (state)
        st_idle: begin
          if (instr_valid) begin
            case (dec.op_class)
              class_load, class_store: begin
                if (ls_misaligned) begin
                  state <= st_trapped;
                end else begin
                  data_go <= 1'b1;
                  state   <= st_mem_wait;
                end
              end
              class_system, class_illegal: state <= st_trapped;
              default: begin
                if (bad_target) begin
                  state <= st_trapped;
                end else begin
                  next_go <= 1'b1;
                end
              end
            endcase
          end
        end
        st_mem_wait: begin
          if (done) begin
            next_go <= 1'b1;
            state   <= st_idle;
          end
        end
        default: state <= st_trapped;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && instr_valid) begin
      next_pc        <= target;
      data_req.addr  <= ls_addr;
      data_req.wdata <= rs2_val;
      data_req.size  <= dec.funct3;
      data_req.write <= dec.op_class == class_store;
      data_req.instr <= 1'b0;
    end
  end

  assign trap = state == st_trapped;

endmodule

// ==== design/rv_fetch.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                reset,
  input  logic                next_go,
  input  logic [`RV_XLEN-1:0] next_pc,
  input  logic                done,
  input  logic [`RV_XLEN-1:0] rdata,
  output logic                fetch_go,
  output rv_pkg::mem_req_t    fetch_req,
  output logic                instr_valid,
  output logic [`RV_XLEN-1:0] instr,
  output logic [`RV_XLEN-1:0] pc
);

  logic boot;
  logic pending;

  always_ff @(posedge clk) begin
    if (!reset) begin
      boot        <= 1'b1;
      fetch_go    <= 1'b0;
      pending     <= 1'b0;
      instr_valid <= 1'b0;
      pc          <= `RV_RESET_PC;
    end else begin
      // one fetch on leaving reset and one per next_go
      boot        <= 1'b0;
      fetch_go    <= boot | next_go;
      instr_valid <= pending & done;
      if (next_go) begin
        pc <= next_pc;
      end
      if (fetch_go) begin
        pending <= 1'b1;
      end else if (done) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pending && done) begin
      instr <= rdata;
    end
  end

  always_comb begin
    fetch_req.addr  = pc;
    fetch_req.wdata = '0;
    fetch_req.size  = 3'b010;
    fetch_req.write = 1'b0;
    fetch_req.instr = 1'b1;
  end

endmodule

// ==== design/rv_mem_port.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_mem_port (
  input  logic                clk,
  input  logic                reset,
  input  logic                fetch_go,
  input  rv_pkg::mem_req_t    fetch_req,
  input  logic                data_go,
  input  rv_pkg::mem_req_t    data_req,
  output logic                mem_valid,
  output logic                mem_instr,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [`RV_XLEN-1:0] mem_wdata,
  output logic [3:0]          mem_wstrb,
  input  logic                mem_ready,
  input  logic [`RV_XLEN-1:0] mem_rdata,
  output logic                done,
  output logic [`RV_XLEN-1:0] rdata
);

  import rv_pkg::*;

  mem_req_t            req;
  logic [3:0]          strb;
  logic [1:0]          lane;
  logic [2:0]          size_q;
  logic [`RV_XLEN-1:0] shifted;
  logic [`RV_XLEN-1:0] load_data;

  // only one requester waits at a time
  assign req = data_go ? data_req : fetch_req;

  always_comb begin
    case (req.size[1:0])
      2'b00:   strb = 4'b0001 << req.addr[1:0];
      2'b01:   strb = 4'b0011 << req.addr[1:0];
      default: strb = 4'b1111;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      mem_valid <= 1'b0;
      mem_wstrb <= 4'b0000;
      done      <= 1'b0;
    end else begin
      done <= mem_valid & mem_ready;
      if (mem_valid && mem_ready) begin
        mem_valid <= 1'b0;
        mem_wstrb <= 4'b0000;
      end else if (fetch_go || data_go) begin
        mem_valid <= 1'b1;
        mem_wstrb <= req.write ? strb : 4'b0000;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_go || data_go) begin
      mem_instr <= req.instr;
      mem_addr  <= {req.addr[`RV_XLEN-1:2], 2'b00};
      mem_wdata <= req.wdata << {req.addr[1:0], 3'b000};
      lane      <= req.addr[1:0];
      size_q    <= req.size;
    end
    if (mem_valid && mem_ready) begin
      rdata <= load_data;
    end
  end

  // addressed byte or halfword down to bit 0
  assign shifted = mem_rdata >> {lane, 3'b000};

  always_comb begin
    case (size_q)
      3'b000:  load_data = {{24{shifted[7]}}, shifted[7:0]};
      3'b001:  load_data = {{16{shifted[15]}}, shifted[15:0]};
      3'b100:  load_data = {24'b0, shifted[7:0]};
      3'b101:  load_data = {16'b0, shifted[15:0]};
      default: load_data = mem_rdata;
    endcase
  end

endmodule

// ==== design/rv_pkg.sv ====
`include "rv_defines.svh"

package rv_pkg;

  // instruction groups after decode
  typedef enum logic [3:0] {
    class_lui,
    class_auipc,
    class_jal,
    class_jalr,
    class_branch,
    class_load,
    class_store,
    class_op_imm,
    class_op,
    class_system,
    class_illegal
  } op_class_e;

  typedef struct packed {
    op_class_e             op_class;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [2:0]            funct3;
    // funct7 bit 5 selects sub and sra
    logic                  alt;
    logic [`RV_XLEN-1:0]   imm;
  } decoded_t;

  // one bus transaction with data not yet in its byte lane
  typedef struct packed {
    logic [`RV_XLEN-1:0]   addr;
    logic [`RV_XLEN-1:0]   wdata;
    logic [2:0]            size;
    logic                  write;
    logic                  instr;
  } mem_req_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, then judge the log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_riscv \
  -o tb_riscv_sim > build.log 2>&1 &&
./obj_dir/tb_riscv_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log &&
{ echo "simulation FAILED"; exit 1; } ||
{ echo "simulation PASSED"; exit 0; }

// ==== tests/riscv_golden.txt ====
// kind test a b c; kind 1 program (addr, instr), 2 store (addr, data, strb)
// kind 3 trap pc (addr), kind 0 ends the list
1 0 00000000 10000513 0
1 0 00000004 FFB00093 0
1 0 00000008 00300113 0
1 0 0000000C 402081B3 0
1 0 00000010 00352023 0
1 0 00000014 4020D233 0
1 0 00000018 001132B3 0
1 0 0000001C 00452223 0
1 0 00000020 00552423 0
1 0 00000024 01C0D393 0
1 0 00000028 00500013 0
1 0 0000002C 00038433 0
1 0 00000030 00852623 0
1 0 00000034 123455B7 0
1 0 00000038 00000617 0
1 0 0000003C 008006EF 0
1 0 00000040 00052023 0
1 0 00000044 01460767 0
1 0 00000048 00052223 0
1 0 0000004C 00B52823 0
1 0 00000050 00C52A23 0
1 0 00000054 00D52C23 0
1 0 00000058 00E52E23 0
1 0 0000005C 00208463 0
1 0 00000060 00106793 0
1 0 00000064 00209463 0
1 0 00000068 0027E793 0
1 0 0000006C 0020C463 0
1 0 00000070 0047E793 0
1 0 00000074 0020D463 0
1 0 00000078 0087E793 0
1 0 0000007C 0020E463 0
1 0 00000080 0107E793 0
1 0 00000084 0020F463 0
1 0 00000088 0207E793 0
1 0 0000008C 02F52023 0
1 0 00000090 021508A3 0
1 0 00000094 02351923 0
1 0 00000098 03150803 0
1 0 0000009C 03052223 0
1 0 000000A0 03154883 0
1 0 000000A4 03152423 0
1 0 000000A8 03251903 0
1 0 000000AC 03252623 0
1 0 000000B0 03255983 0
1 0 000000B4 03352A23 0
1 0 000000B8 00252A03 0
2 0 00000100 FFFFFFF8 F
2 0 00000104 FFFFFFFF F
2 0 00000108 00000001 F
2 0 0000010C 0000000F F
2 0 00000110 12345000 F
2 0 00000114 00000038 F
2 0 00000118 00000040 F
2 0 0000011C 00000048 F
2 0 00000120 00000019 F
2 0 00000130 FFFFFB00 2
2 0 00000130 FFF80000 C
2 0 00000124 FFFFFFFB F
2 0 00000128 000000FB F
2 0 0000012C FFFFFFF8 F
2 0 00000134 0000FFF8 F
3 0 000000B8 0 0
1 1 00000000 00700093 0
1 1 00000004 20102023 0
1 1 00000008 00100073 0
2 1 00000200 00000007 F
3 1 00000008 0 0
0 0 0 0 0

// ==== tests/tb_riscv.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_riscv;

  localparam int GOLDEN_WORDS = 512;
  localparam int MEM_WORDS    = 1024;
  localparam int RUN_LIMIT    = 5000;
  localparam int IDLE_CHECK   = 20;

  logic                clk;
  logic                reset;
  logic                mem_valid;
  logic                mem_instr;
  logic                mem_ready;
  logic [`RV_XLEN-1:0] mem_addr;
  logic [`RV_XLEN-1:0] mem_wdata;
  logic [3:0]          mem_wstrb;
  logic [`RV_XLEN-1:0] mem_rdata;
  logic                trap;

  logic [31:0] golden [GOLDEN_WORDS];
  logic [31:0] mem [MEM_WORDS];
  bit          prog_word [MEM_WORDS];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_strb [$];
  logic [31:0] trap_pc;
  logic [31:0] last_fetch;
  logic        first_fetch;
  int          errors;
  int          timeouts;

  riscv UUT (
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_instr(mem_instr),
    .mem_ready(mem_ready), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb), .mem_rdata(mem_rdata), .trap(trap)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // memory image and expected records of one test
  task automatic load_test(input int test);
    int i;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[i]       = 32'h5a5a_0000 ^ (i << 2);
      prog_word[i] = 1'b0;
    end
    exp_addr.delete();
    exp_data.delete();
    exp_strb.delete();
    trap_pc = '1;
    i = 0;
    while (i + 4 < GOLDEN_WORDS && golden[i] != 32'd0) begin
      if (golden[i+1] == test) begin
        case (golden[i])
          32'd1: begin
            mem[golden[i+2][11:2]]       = golden[i+3];
            prog_word[golden[i+2][11:2]] = 1'b1;
          end
          32'd2: begin
            exp_addr.push_back(golden[i+2]);
            exp_data.push_back(golden[i+3]);
            exp_strb.push_back(golden[i+4]);
          end
          32'd3: trap_pc = golden[i+2];
          default: ;
        endcase
      end
      i += 5;
    end
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb);
    if (exp_addr.size() == 0) begin
      errors++;
      $display("ERROR %0t: unexpected store addr %h data %h strb %b", $time, addr, wdata,
               strb);
    end else begin
      if (addr != exp_addr[0] || wdata != exp_data[0] || strb != exp_strb[0][3:0]) begin
        errors++;
        $display("ERROR %0t: store addr %h data %h strb %b, expected %h %h %b", $time, addr,
                 wdata, strb, exp_addr[0], exp_data[0], exp_strb[0][3:0]);
      end
      exp_addr.pop_front();
      exp_data.pop_front();
      exp_strb.pop_front();
    end
  endtask

  // one bus transaction with an optional ready delay
  task automatic serve_request(input bit random_delay);
    int          delay;
    int          d;
    int          b;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic        instr;
    delay = random_delay ? int'($urandom % 4) : 0;
    addr  = mem_addr;
    wdata = mem_wdata;
    strb  = mem_wstrb;
    instr = mem_instr;
    if (instr) begin
      if (first_fetch && addr != `RV_RESET_PC) begin
        errors++;
        $display("ERROR %0t: first fetch at %h", $time, addr);
      end
      if (addr[31:12] != '0 || !prog_word[addr[11:2]]) begin
        errors++;
        $display("ERROR %0t: fetch at %h outside the program", $time, addr);
      end
      first_fetch = 1'b0;
      last_fetch  = addr;
    end
    for (d = 0; d < delay; d++) begin
      @(posedge clk);
      #1;
      if (mem_valid !== 1'b1 || mem_addr !== addr || mem_wdata !== wdata ||
          mem_wstrb !== strb || mem_instr !== instr) begin
        errors++;
        $display("ERROR %0t: request changed before mem_ready", $time);
      end
    end
    mem_ready = 1'b1;
    mem_rdata = mem[addr[11:2]];
    if (strb != 4'b0000) begin
      for (b = 0; b < 4; b++) begin
        if (strb[b]) mem[addr[11:2]][b*8 +: 8] = wdata[b*8 +: 8];
      end
      check_store(addr, wdata, strb);
    end
    @(posedge clk);
    #1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    if (mem_valid !== 1'b0) begin
      errors++;
      $display("ERROR %0t: mem_valid still high after accept", $time);
    end
  endtask

  task automatic run_test(input int test, input bit random_delay);
    int cycles;
    int i;
    load_test(test);
    reset     = 1'b0;
    mem_ready = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset       = 1'b1;
    first_fetch = 1'b1;
    last_fetch  = '1;
    cycles      = 0;
    while (trap !== 1'b1 && cycles < RUN_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
      if (mem_valid === 1'b1) serve_request(random_delay);
    end
    if (cycles >= RUN_LIMIT) begin
      timeouts++;
      $display("Timeout: test %0d never raised trap", test);
    end else begin
      if (last_fetch != trap_pc) begin
        errors++;
        $display("ERROR %0t: last fetch %h, expected trap pc %h", $time, last_fetch, trap_pc);
      end
      if (exp_addr.size() != 0) begin
        errors++;
        $display("ERROR %0t: %0d expected stores missing", $time, exp_addr.size());
      end
      // core must stay quiet once trapped
      for (i = 0; i < IDLE_CHECK; i++) begin
        @(posedge clk);
        #1;
        if (mem_valid !== 1'b0 || trap !== 1'b1) begin
          errors++;
          $display("ERROR %0t: bus activity or trap low after trap", $time);
        end
      end
    end
  endtask

  initial begin
    errors    = 0;
    timeouts  = 0;
    reset     = 1'b0;
    mem_ready = 1'b0;
    mem_rdata = '0;
    void'($urandom(32'h6972541c));
    $readmemh("tests/riscv_golden.txt", golden);
    run_test(0, 1'b0);
    if (timeouts == 0) run_test(0, 1'b1);
    if (timeouts == 0) run_test(1, 1'b1);
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+design
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_mem_port.sv
design/riscv.sv
tests/tb_riscv.sv
